// ==== list.f ====
rtl/msdft_pkg.sv
rtl/msdft_comb.sv
rtl/msdft_config.sv
rtl/complex_mult.sv
rtl/bin_accumulator.sv
rtl/msdft_top.sv
bench/msdft_tb.sv

// ==== Makefile ====
# Verilator build for the sliding DFT bin testbench

VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= msdft_tb
FILES     ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

# static checks only
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILES)

# build and run, exit status follows the testbench result
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILES) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/msdft_tb.sv ====
module msdft_tb
    import msdft_pkg::*;
();

    localparam int DFT_LEN       = 16;
    localparam int IDX_W         = $clog2(DFT_LEN);
    localparam int ACC_W         = PROD_WIDTH + IDX_W;
    localparam int LATENCY       = 6;
    localparam int DRAIN_TIMEOUT = 200;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    localparam logic [15:0] LFSR_SEED = 16'd39108;

    logic               clk;
    logic               rst;
    sample_t            din_re;
    sample_t            din_im;
    logic               din_valid;
    logic               twidd_we;
    logic [IDX_W-1:0]   twidd_addr;
    twidd_word_t        twidd_data;
    logic               len_we;
    logic [IDX_W-1:0]   len_data;
    dout_t              dout_re;
    dout_t              dout_im;
    logic               dout_valid;

    logic [15:0]        lfsr_state = LFSR_SEED;
    // rising edges seen so far
    int unsigned        cyc = 0;

    // reference model state
    int                      m_hist_re [DFT_LEN];
    int                      m_hist_im [DFT_LEN];
    int                      m_tab_re [DFT_LEN];
    int                      m_tab_im [DFT_LEN];
    int                      m_ptr;
    int                      m_idx;
    int                      m_len;
    logic signed [ACC_W-1:0] m_acc_re;
    logic signed [ACC_W-1:0] m_acc_im;
    longint                  exp_re_q [$];
    longint                  exp_im_q [$];
    int unsigned             exp_cyc_q [$];
    int                      sent_count = 0;
    int                      out_count = 0;

    msdft_top #(
        .DFT_LEN    (DFT_LEN)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .din_re     (din_re),
        .din_im     (din_im),
        .din_valid  (din_valid),
        .twidd_we   (twidd_we),
        .twidd_addr (twidd_addr),
        .twidd_data (twidd_data),
        .len_we     (len_we),
        .len_data   (len_data),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        b;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            bits = {bits[30:0], b};
        end
        return bits;
    endfunction

    // two's complement value of n random bits
    function automatic int rand_signed(input int n);
        logic [31:0] bits;
        int          v;
        bits = rand_bits(n);
        v = int'(bits);
        if (bits[n-1]) begin
            v = v - (1 << n);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            $display("ERR %0t %s actual %0d expected %0d", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // fresh window: empty history, index and accumulator at zero
    task automatic model_restart(input int n);
        for (int i = 0; i < DFT_LEN; i++) begin
            m_hist_re[i] = 0;
            m_hist_im[i] = 0;
        end
        m_len    = n - 1;
        m_ptr    = 0;
        m_idx    = 0;
        m_acc_re = '0;
        m_acc_im = '0;
    endtask

    task automatic model_sample(input int x_re, input int x_im);
        int     y_re;
        int     y_im;
        int     w_re;
        int     w_im;
        longint p_re;
        longint p_im;
        longint acc;
        // comb against the sample N steps back
        y_re = x_re - m_hist_re[m_ptr];
        y_im = x_im - m_hist_im[m_ptr];
        m_hist_re[m_ptr] = x_re;
        m_hist_im[m_ptr] = x_im;
        m_ptr = (m_ptr == m_len) ? 0 : m_ptr + 1;
        w_re = m_tab_re[m_idx];
        w_im = m_tab_im[m_idx];
        m_idx = (m_idx == m_len) ? 0 : m_idx + 1;
        p_re = longint'(y_re) * w_re - longint'(y_im) * w_im;
        p_im = longint'(y_re) * w_im + longint'(y_im) * w_re;
        m_acc_re = m_acc_re + ACC_W'(p_re);
        m_acc_im = m_acc_im + ACC_W'(p_im);
        acc = longint'(m_acc_re);
        exp_re_q.push_back(acc >>> OUT_SHIFT);
        acc = longint'(m_acc_im);
        exp_im_q.push_back(acc >>> OUT_SHIFT);
        exp_cyc_q.push_back(cyc + LATENCY);
        sent_count++;
    endtask

    task automatic idle(input int n);
        din_valid = 1'b0;
        twidd_we  = 1'b0;
        len_we    = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drive_sample(input int x_re, input int x_im);
        din_re    = sample_t'(x_re);
        din_im    = sample_t'(x_im);
        din_valid = 1'b1;
        model_sample(x_re, x_im);
        @(negedge clk);
        din_valid = 1'b0;
    endtask

    task automatic write_twiddle(input int addr, input int w_re, input int w_im);
        twidd_we   = 1'b1;
        twidd_addr = IDX_W'(addr);
        twidd_data = {twiddle_t'(w_im), twiddle_t'(w_re)};
        m_tab_re[addr] = w_re;
        m_tab_im[addr] = w_im;
        @(negedge clk);
        twidd_we = 1'b0;
    endtask

    task automatic write_length(input int n);
        // pipeline must be empty first
        idle(8);
        len_we   = 1'b1;
        len_data = IDX_W'(n - 1);
        @(negedge clk);
        len_we = 1'b0;
        // clear is still high in the next cycle
        idle(2);
        model_restart(n);
    endtask

    task automatic send_burst(input int count, input int gap_bits);
        int gap;
        int x_re;
        int x_im;
        for (int i = 0; i < count; i++) begin
            if (gap_bits > 0) begin
                gap = int'(rand_bits(gap_bits));
                idle(gap);
            end
            x_re = rand_signed(DIN_WIDTH);
            x_im = rand_signed(DIN_WIDTH);
            drive_sample(x_re, x_im);
        end
    endtask

    task automatic wait_drain();
        for (int i = 0; i < DRAIN_TIMEOUT; i++) begin
            @(posedge clk);
            if (exp_re_q.size() == 0) begin
                @(negedge clk);
                return;
            end
        end
        $display("Checks failed");
        $fatal(1, "outputs still missing after %0d cycles", DRAIN_TIMEOUT);
    endtask

    // outputs are registered on the rising edge, look at them on the falling one
    always @(negedge clk) begin
        if (!rst && dout_valid) begin
            if (exp_re_q.size() == 0) begin
                $display("Checks failed");
                $fatal(1, "output strobe at %0t with no sample outstanding", $time);
            end else begin
                check_value("dout_re", dout_re, exp_re_q.pop_front());
                check_value("dout_im", dout_im, exp_im_q.pop_front());
                check_value("dout_valid cycle", cyc, exp_cyc_q.pop_front());
                out_count++;
            end
        end
    end

    initial begin
        int addr;
        int w_re;
        int w_im;
        rst        = 1'b1;
        din_re     = '0;
        din_im     = '0;
        din_valid  = 1'b0;
        twidd_we   = 1'b0;
        twidd_addr = '0;
        twidd_data = '0;
        len_we     = 1'b0;
        len_data   = '0;
        for (int i = 0; i < DFT_LEN; i++) begin
            m_tab_re[i] = 0;
            m_tab_im[i] = 0;
        end
        model_restart(DFT_LEN);
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // quiet output before any sample
        for (int i = 0; i < 20; i++) begin
            check_value("dout_valid", longint'(dout_valid), 0);
            @(negedge clk);
        end

        // unit twiddles, back to back samples
        for (int a = 0; a < DFT_LEN; a++) begin
            write_twiddle(a, 1 << TWIDD_POINT, 0);
        end
        idle(2);
        send_burst(40, 0);
        wait_drain();

        // random table, random gaps
        for (int a = 0; a < DFT_LEN; a++) begin
            w_re = rand_signed(TWIDD_WIDTH);
            w_im = rand_signed(TWIDD_WIDTH);
            write_twiddle(a, w_re, w_im);
        end
        idle(2);
        send_burst(60, 2);
        wait_drain();

        // short window of 5
        write_length(5);
        send_burst(40, 1);
        wait_drain();

        // one entry rewritten between bursts
        send_burst(20, 1);
        wait_drain();
        addr = int'(rand_bits(2));
        w_re = rand_signed(TWIDD_WIDTH);
        w_im = rand_signed(TWIDD_WIDTH);
        write_twiddle(addr, w_re, w_im);
        idle(2);
        send_burst(20, 1);
        wait_drain();

        idle(10);
        if (exp_re_q.size() == 0 && out_count == sent_count) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "%0d samples sent but %0d outputs seen", sent_count, out_count);
        end
    end

endmodule

// ==== rtl/msdft_top.sv ====
module msdft_top
    import msdft_pkg::*;
#(
    parameter int DFT_LEN = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  sample_t                    din_re,
    input  sample_t                    din_im,
    input  logic                       din_valid,
    input  logic                       twidd_we,
    input  logic [$clog2(DFT_LEN)-1:0] twidd_addr,
    input  twidd_word_t                twidd_data,
    input  logic                       len_we,
    input  logic [$clog2(DFT_LEN)-1:0] len_data,
    output dout_t                      dout_re,
    output dout_t                      dout_im,
    output logic                       dout_valid
);

    localparam int IDX_W = $clog2(DFT_LEN);

    logic [IDX_W-1:0] len;
    logic             clear;
    comb_t            comb_re;
    comb_t            comb_im;
    logic             comb_valid;
    twiddle_t         twidd_re;
    twiddle_t         twidd_im;
    prod_t            prod_re;
    prod_t            prod_im;
    logic             prod_valid;

    // the real comb supplies the shared valid strobe
    msdft_comb #(
        .DFT_LEN    (DFT_LEN)
    ) comb_re_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .din        (din_re),
        .din_valid  (din_valid),
        .len        (len),
        .dout       (comb_re),
        .dout_valid (comb_valid)
    );

    msdft_comb #(
        .DFT_LEN    (DFT_LEN)
    ) comb_im_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .din        (din_im),
        .din_valid  (din_valid),
        .len        (len),
        .dout       (comb_im),
        .dout_valid ()
    );

    msdft_config #(
        .DFT_LEN    (DFT_LEN)
    ) config_i (
        .clk        (clk),
        .rst        (rst),
        .twidd_we   (twidd_we),
        .twidd_addr (twidd_addr),
        .twidd_data (twidd_data),
        .len_we     (len_we),
        .len_data   (len_data),
        .step       (comb_valid),
        .len        (len),
        .clear      (clear),
        .twidd_re   (twidd_re),
        .twidd_im   (twidd_im)
    );

    complex_mult mult_i (
        .clk        (clk),
        .rst        (rst),
        .a_re       (comb_re),
        .a_im       (comb_im),
        .a_valid    (comb_valid),
        .w_re       (twidd_re),
        .w_im       (twidd_im),
        .p_re       (prod_re),
        .p_im       (prod_im),
        .p_valid    (prod_valid)
    );

    bin_accumulator #(
        .DFT_LEN    (DFT_LEN)
    ) acc_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .p_re       (prod_re),
        .p_im       (prod_im),
        .p_valid    (prod_valid),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid)
    );

endmodule

// ==== rtl/bin_accumulator.sv ====
module bin_accumulator
    import msdft_pkg::*;
#(
    parameter int DFT_LEN = 128
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  clear,
    input  prod_t p_re,
    input  prod_t p_im,
    input  logic  p_valid,
    output dout_t dout_re,
    output dout_t dout_im,
    output logic  dout_valid
);

    // room for a full window of products
    localparam int ACC_W = PROD_WIDTH + $clog2(DFT_LEN);

    logic signed [ACC_W-1:0] acc_re;
    logic signed [ACC_W-1:0] acc_im;
    logic                    acc_valid;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc_re <= '0;
            acc_im <= '0;
        end else if (p_valid) begin
            acc_re <= acc_re + ACC_W'(p_re);
            acc_im <= acc_im + ACC_W'(p_im);
        end
    end

    // arithmetic shift, rounds towards minus infinity
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            dout_re <= dout_t'(acc_re >>> OUT_SHIFT);
            dout_im <= dout_t'(acc_im >>> OUT_SHIFT);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_valid  <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            acc_valid  <= p_valid;
            dout_valid <= acc_valid;
        end
    end

endmodule

// ==== rtl/complex_mult.sv ====
module complex_mult
    import msdft_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  comb_t    a_re,
    input  comb_t    a_im,
    input  logic     a_valid,
    input  twiddle_t w_re,
    input  twiddle_t w_im,
    output prod_t    p_re,
    output prod_t    p_im,
    output logic     p_valid
);

    localparam int PART_W = COMB_WIDTH + TWIDD_WIDTH;

    comb_t                     a_re_q;
    comb_t                     a_im_q;
    logic                      a_valid_q;
    logic signed [PART_W-1:0]  rr;
    logic signed [PART_W-1:0]  ii;
    logic signed [PART_W-1:0]  ri;
    logic signed [PART_W-1:0]  ir;
    logic                      part_valid;

    // comb operand waits one cycle for the table read
    always_ff @(posedge clk) begin
        a_re_q <= a_re;
        a_im_q <= a_im;
    end

    // partial products
    always_ff @(posedge clk) begin
        rr <= a_re_q * w_re;
        ii <= a_im_q * w_im;
        ri <= a_re_q * w_im;
        ir <= a_im_q * w_re;
    end

    // (a_re + j a_im)(w_re + j w_im)
    always_ff @(posedge clk) begin
        p_re <= prod_t'(rr) - prod_t'(ii);
        p_im <= prod_t'(ri) + prod_t'(ir);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid_q  <= 1'b0;
            part_valid <= 1'b0;
            p_valid    <= 1'b0;
        end else begin
            a_valid_q  <= a_valid;
            part_valid <= a_valid_q;
            p_valid    <= part_valid;
        end
    end

endmodule

// ==== rtl/msdft_config.sv ====
module msdft_config
    import msdft_pkg::*;
#(
    parameter int DFT_LEN = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       twidd_we,
    input  logic [$clog2(DFT_LEN)-1:0] twidd_addr,
    input  twidd_word_t                twidd_data,
    input  logic                       len_we,
    input  logic [$clog2(DFT_LEN)-1:0] len_data,
    input  logic                       step,
    output logic [$clog2(DFT_LEN)-1:0] len,
    output logic                       clear,
    output twiddle_t                   twidd_re,
    output twiddle_t                   twidd_im
);

    localparam int IDX_W = $clog2(DFT_LEN);

    twidd_word_t        twidd_mem [DFT_LEN];
    logic [IDX_W-1:0]   twidd_idx;
    twidd_word_t        rd_word;

    // table starts out zeroed and is loaded by the host
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DFT_LEN; i++) begin
                twidd_mem[i] <= '0;
            end
        end else if (twidd_we) begin
            twidd_mem[twidd_addr] <= twidd_data;
        end
    end

    // window length register, N-1
    always_ff @(posedge clk) begin
        if (rst) begin
            len   <= IDX_W'(DFT_LEN - 1);
            clear <= 1'b0;
        end else begin
            clear <= len_we;
            if (len_we) begin
                len <= len_data;
            end
        end
    end

    // modulo-N index, one step per comb output
    always_ff @(posedge clk) begin
        if (rst || len_we) begin
            twidd_idx <= '0;
        end else if (step) begin
            if (twidd_idx == len) begin
                twidd_idx <= '0;
            end else begin
                twidd_idx <= twidd_idx + 1'b1;
            end
        end
    end

    // read at the index before it advances
    always_ff @(posedge clk) begin
        if (step) begin
            rd_word <= twidd_mem[twidd_idx];
        end
    end

    assign twidd_re = twiddle_t'(rd_word[TWIDD_WIDTH-1:0]);
    assign twidd_im = twiddle_t'(rd_word[2*TWIDD_WIDTH-1:TWIDD_WIDTH]);

endmodule

// ==== rtl/msdft_comb.sv ====
module msdft_comb
    import msdft_pkg::*;
#(
    parameter int DFT_LEN = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  sample_t                    din,
    input  logic                       din_valid,
    input  logic [$clog2(DFT_LEN)-1:0] len,
    output comb_t                      dout,
    output logic                       dout_valid
);

    localparam int IDX_W = $clog2(DFT_LEN);

    sample_t            hist_mem [DFT_LEN];
    logic [IDX_W-1:0]   wr_ptr;
    // set once the window has been filled a first time
    logic               hist_full;
    sample_t            old_sample;

    // sample from N steps back, zero until the window has filled
    assign old_sample = hist_full ? hist_mem[wr_ptr] : '0;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            hist_mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr    <= '0;
            hist_full <= 1'b0;
        end else if (din_valid) begin
            if (wr_ptr == len) begin
                wr_ptr    <= '0;
                hist_full <= 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            dout <= comb_t'(din) - comb_t'(old_sample);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

endmodule

// ==== rtl/msdft_pkg.sv ====
package msdft_pkg;

    // input samples, Q1.7
    localparam int DIN_WIDTH = 8;
    localparam int DIN_POINT = 7;

    // twiddle factors, Q2.14
    localparam int TWIDD_WIDTH = 16;
    localparam int TWIDD_POINT = 14;

    // comb output grows by one bit
    localparam int COMB_WIDTH = DIN_WIDTH + 1;

    // comb times twiddle, plus one bit for the sum of two products
    localparam int PROD_WIDTH = COMB_WIDTH + TWIDD_WIDTH + 1;

    // output format
    localparam int DOUT_WIDTH = 32;
    localparam int DOUT_POINT = 16;

    // fractional bits dropped when narrowing the accumulator
    localparam int OUT_SHIFT = DIN_POINT + TWIDD_POINT - DOUT_POINT;

    typedef logic signed [DIN_WIDTH-1:0]   sample_t;
    typedef logic signed [COMB_WIDTH-1:0]  comb_t;
    typedef logic signed [TWIDD_WIDTH-1:0] twiddle_t;
    typedef logic signed [PROD_WIDTH-1:0]  prod_t;
    typedef logic signed [DOUT_WIDTH-1:0]  dout_t;

    // {imag, real}
    typedef logic [2*TWIDD_WIDTH-1:0] twidd_word_t;

endpackage
